// File: lfsr_crc_engine.sv
//********************************************************************
// msb-first crc accumulator over 16-bit words, crc-8/16/32/64,
// with a one-cycle strobe once the last word of a frame is folded in.
//********************************************************************

`timescale 1ns/100ps

module lfsr_crc_engine #(
    parameter int CRC_W = 32
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              init_i,
    input  lfsr_pkg::stream_t word_i,
    output logic [CRC_W-1:0]  crc_o,
    output logic              crc_valid_o
);

    //****************************************************************
    // polynomial selection
    //****************************************************************

    if ((CRC_W != 8) && (CRC_W != 16) && (CRC_W != 32) && (CRC_W != 64)) begin : g_crc_w_err
        $error("lfsr_crc_engine: CRC_W must be 8, 16, 32 or 64");
    end

    // x^8+x^2+x+1, x^16+x^12+x^5+1, crc-32 mpeg-2, x^64+x^4+x^3+x+1.
    localparam logic [63:0] POLY_FULL =
        (CRC_W == 8)  ? 64'h0000_0000_0000_0007 :
        (CRC_W == 16) ? 64'h0000_0000_0000_1021 :
        (CRC_W == 32) ? 64'h0000_0000_04C1_1DB7 :
                        64'h0000_0000_0000_001B;

    localparam logic [CRC_W-1:0] POLY = CRC_W'(POLY_FULL);

    //****************************************************************
    // per-bit and per-word update
    //****************************************************************

    // one shift of the crc register with one data bit.
    function automatic logic [CRC_W-1:0] crc_bit(
        input logic [CRC_W-1:0] crc,
        input logic             data
    );
        logic fb;
        fb = crc[CRC_W-1] ^ data;
        return {crc[CRC_W-2:0], 1'b0} ^ (fb ? POLY : '0);
    endfunction

    // whole word, msb first.
    function automatic logic [CRC_W-1:0] crc_word(
        input logic [CRC_W-1:0] crc,
        input lfsr_pkg::word_t  data
    );
        logic [CRC_W-1:0] acc;
        acc = crc;
        for (int i = lfsr_pkg::WORD_W - 1; i >= 0; i--) begin
            acc = crc_bit(acc, data[i]);
        end
        return acc;
    endfunction

    //****************************************************************
    // registers
    //****************************************************************

    logic [CRC_W-1:0] crc_q;

    // init wins over a word in the same cycle.
    always_ff @(posedge clk_i) begin
        if (init_i) begin
            crc_q <= '1;
        end else if (word_i.valid) begin
            crc_q <= crc_word(crc_q, word_i.data);
        end
    end

    // done strobe, one cycle after the last word.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            crc_valid_o <= 1'b0;
        end else begin
            crc_valid_o <= word_i.valid & word_i.last;
        end
    end

    assign crc_o = crc_q;

endmodule

// File: lfsr_frame_ctrl.sv
//********************************************************************
// frame controller: start handling, word count, last flag and
// wait for the crc result.
//********************************************************************

`timescale 1ns/100ps

module lfsr_frame_ctrl (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            start_i,
    input  lfsr_pkg::len_t  len_i,
    input  logic            crc_done_i,
    output logic            load_o,
    output lfsr_pkg::step_t step_o,
    output logic            busy_o
);

    lfsr_pkg::frame_state_e state_q;
    lfsr_pkg::frame_state_e state_d;
    lfsr_pkg::len_t         cnt_q;   // words still to emit.
    lfsr_pkg::len_t         cnt_d;
    logic                   last_word;

    assign last_word = (cnt_q == lfsr_pkg::len_t'(1));

    //****************************************************************
    // next state
    //****************************************************************

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            lfsr_pkg::IDLE: begin
                if (start_i) begin
                    state_d = lfsr_pkg::RUN;
                    cnt_d   = len_i;  // len is sampled here only.
                end
            end
            lfsr_pkg::RUN: begin
                cnt_d = cnt_q - lfsr_pkg::len_t'(1);
                if (last_word) begin
                    state_d = lfsr_pkg::WAIT_CRC;
                end
            end
            lfsr_pkg::WAIT_CRC: begin
                if (crc_done_i) begin
                    state_d = lfsr_pkg::IDLE;
                end
            end
            default: begin
                state_d = lfsr_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= lfsr_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    //****************************************************************
    // outputs
    //****************************************************************

    // load goes out in the start cycle, so seed and crc are set at that edge.
    assign load_o = (state_q == lfsr_pkg::IDLE) & start_i;

    assign step_o.step = (state_q == lfsr_pkg::RUN);
    assign step_o.last = (state_q == lfsr_pkg::RUN) & last_word;

    assign busy_o = (state_q != lfsr_pkg::IDLE);  // starts are ignored while set.

endmodule

// File: lfsr_frame_ref.svh
//********************************************************************
// reference models for the lfsr step and the crc polynomials.
//********************************************************************

`ifndef LFSR_FRAME_REF_SVH
`define LFSR_FRAME_REF_SVH

// one fibonacci step, tap parity shifted in at bit 0.
function automatic lfsr_pkg::word_t ref_lfsr_step(
    input lfsr_pkg::word_t state,
    input lfsr_pkg::word_t poly
);
    return {state[lfsr_pkg::WORD_W-2:0], ^(state & poly)};
endfunction

// polynomial without the top term, for each supported width.
function automatic logic [63:0] ref_crc_poly(input int crc_w);
    case (crc_w)
        8:       return 64'h07;
        16:      return 64'h1021;
        32:      return 64'h04C1_1DB7;
        default: return 64'h1B;
    endcase
endfunction

// crc over a word queue, msb first, register starts at all ones.
function automatic logic [63:0] ref_crc(
    input int              crc_w,
    input lfsr_pkg::word_t words[$]
);
    logic [63:0] mask;
    logic [63:0] crc;
    logic        fb;
    mask = (crc_w == 64) ? '1 : ((64'd1 << crc_w) - 64'd1);
    crc  = mask;
    foreach (words[w]) begin
        for (int b = lfsr_pkg::WORD_W - 1; b >= 0; b--) begin
            fb  = crc[crc_w-1] ^ words[w][b];
            crc = ((crc << 1) ^ (fb ? ref_crc_poly(crc_w) : 64'd0)) & mask;
        end
    end
    return crc;
endfunction

`endif

// File: lfsr_frame_tb.sv
//********************************************************************
// testbench for the frame pattern source with random frames, start
// while busy and back-to-back frames, checked each cycle.
//********************************************************************

`timescale 1ns/100ps

module lfsr_frame_tb;

    localparam int CRC_W      = lfsr_pkg::CRC_W_DEF;
    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;   // input drive offset after the rising edge.
    localparam int RST_CYCLES = 5;

    `include "lfsr_frame_ref.svh"

    logic              clk = 1'b0;
    logic              rstn;
    logic              start;
    lfsr_pkg::len_t    len;
    lfsr_pkg::word_t   seed;
    lfsr_pkg::word_t   poly;
    lfsr_pkg::stream_t stream;
    logic [CRC_W-1:0]  crc;
    logic              crc_valid;
    logic              busy;

    //****************************************************************
    // expected frame as set by the driver at each accepted start
    //****************************************************************

    string           test_name    = "reset_state";
    logic            frame_active = 1'b0;
    int              start_edge;      // cycle count of the edge that takes start.
    int              exp_len;
    lfsr_pkg::word_t exp_poly;
    lfsr_pkg::word_t next_word;
    lfsr_pkg::word_t frame_words[$];  // expected words of this frame so far.
    int              frames_done  = 0;
    int              cyc          = 0;
    int              frame_len[$];
    int              budget;
    int              rnd_seed;

    logic            busy_exp;
    logic            valid_exp;
    logic            last_exp;
    logic            crc_valid_exp;
    logic [63:0]     crc_ref;

    lfsr_frame_top #(.CRC_W(CRC_W)) dut (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .start_i     (start),
        .len_i       (len),
        .seed_i      (seed),
        .poly_i      (poly),
        .word_o      (stream),
        .crc_o       (crc),
        .crc_valid_o (crc_valid),
        .busy_o      (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //****************************************************************
    // error handling
    //****************************************************************

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(
        input string       what,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        stop_on_error($sformatf("[ERROR] %s: %s expected 0x%0h, actual 0x%0h",
                                test_name, what, expected, actual));
    endtask

    //****************************************************************
    // monitor sampling in the middle of the cycle
    //****************************************************************

    always @(negedge clk) begin
        if (rstn) begin
            // word k is out in the cycle after edge start_edge+k.
            busy_exp      = frame_active && (cyc >= start_edge)
                            && (cyc <= start_edge + exp_len + 1);
            valid_exp     = frame_active && (cyc > start_edge) && (cyc <= start_edge + exp_len);
            last_exp      = frame_active && (cyc == start_edge + exp_len);
            crc_valid_exp = frame_active && (cyc == start_edge + exp_len + 1);
            assert (busy === busy_exp) else report_mismatch("busy_o", busy_exp, busy);
            assert (stream.valid === valid_exp)
                else report_mismatch("word valid", valid_exp, stream.valid);
            assert (stream.last === last_exp)
                else report_mismatch("word last", last_exp, stream.last);
            assert (crc_valid === crc_valid_exp)
                else report_mismatch("crc_valid_o", crc_valid_exp, crc_valid);
            if (valid_exp) begin
                assert (stream.data === next_word)
                    else report_mismatch($sformatf("word %0d", frame_words.size() + 1),
                                         next_word, stream.data);
                frame_words.push_back(next_word);
                next_word = ref_lfsr_step(next_word, exp_poly);
            end
            if (crc_valid_exp) begin
                crc_ref = ref_crc(CRC_W, frame_words);
                assert (crc === crc_ref[CRC_W-1:0]) else report_mismatch("crc_o", crc_ref, crc);
                frames_done++;
            end
        end
    end

    //****************************************************************
    // stimulus
    //****************************************************************

    // runs one frame with a random seed and poly from drive time.
    task automatic run_frame(
        input string name,
        input int    n,
        input bit    poke_busy,
        input bit    next_back_to_back
    );
        lfsr_pkg::word_t s;
        lfsr_pkg::word_t p;
        int              done_before;
        done_before  = frames_done;
        s            = lfsr_pkg::word_t'($urandom_range(16'hFFFF, 1));
        p            = lfsr_pkg::word_t'($urandom_range(16'hFFFF, 1));
        test_name    = name;
        exp_len      = n;
        exp_poly     = p;
        next_word    = s;
        frame_words.delete();
        start_edge   = cyc + 1;
        frame_active = 1'b1;
        start        = 1'b1;
        len          = lfsr_pkg::len_t'(n);
        seed         = s;
        poly         = p;
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b0;
        len   = lfsr_pkg::len_t'($urandom);  // only sampled with start.
        seed  = lfsr_pkg::word_t'($urandom);
        poly  = lfsr_pkg::word_t'($urandom);
        if (poke_busy) begin
            repeat (3) @(posedge clk);
            #DRIVE_DLY;
            start = 1'b1;  // lands in RUN.
            @(posedge clk);
            #DRIVE_DLY;
            start = 1'b0;
            repeat (n - 4) @(posedge clk);
            #DRIVE_DLY;
            start = 1'b1;  // lands in WAIT_CRC.
            @(posedge clk);
            #DRIVE_DLY;
            start = 1'b0;
        end
        wait (frames_done == done_before + 1);
        @(posedge clk);
        if (!next_back_to_back) begin
            repeat (2) @(posedge clk);
        end
        #DRIVE_DLY;
    endtask

    initial begin
        rstn     = 1'b0;
        start    = 1'b0;
        len      = '0;
        seed     = '0;
        poly     = '0;
        rnd_seed = 7755;
        void'($urandom(rnd_seed));

        frame_len.push_back(1);
        frame_len.push_back(255);
        repeat (4) frame_len.push_back($urandom_range(40, 2));
        frame_len.push_back(20);                       // start while busy.
        frame_len.push_back($urandom_range(30, 2));    // back-to-back pair.
        frame_len.push_back($urandom_range(30, 2));

        budget = RST_CYCLES + 60;
        foreach (frame_len[i]) begin
            budget += frame_len[i] + 4 + 3;
        end

        fork
            begin
                #(budget * CLK_PERIOD);
                stop_on_error($sformatf("timeout: frames not finished after %0d clock cycles",
                                        budget));
            end
        join_none

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rstn = 1'b1;
        repeat (3) @(posedge clk);  // outputs must stay low before any start.
        #DRIVE_DLY;

        run_frame("len_one", frame_len[0], 1'b0, 1'b0);
        run_frame("len_max", frame_len[1], 1'b0, 1'b0);
        for (int i = 2; i < 6; i++) begin
            run_frame($sformatf("random_%0d", i - 1), frame_len[i], 1'b0, 1'b0);
        end
        run_frame("start_busy", frame_len[6], 1'b1, 1'b0);
        run_frame("back_to_back_a", frame_len[7], 1'b0, 1'b1);
        run_frame("back_to_back_b", frame_len[8], 1'b0, 1'b0);
        repeat (3) @(posedge clk);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: lfsr_frame_top.sv
//********************************************************************
// frame pattern source top: controller, lfsr generator, crc engine.
//********************************************************************

`timescale 1ns/100ps

module lfsr_frame_top #(
    parameter int CRC_W = lfsr_pkg::CRC_W_DEF
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              start_i,
    input  lfsr_pkg::len_t    len_i,
    input  lfsr_pkg::word_t   seed_i,
    input  lfsr_pkg::word_t   poly_i,
    output lfsr_pkg::stream_t word_o,
    output logic [CRC_W-1:0]  crc_o,
    output logic              crc_valid_o,
    output logic              busy_o
);

    logic            load;   // reloads the lfsr and clears the crc.
    lfsr_pkg::step_t step;

    lfsr_frame_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (start_i),
        .len_i      (len_i),
        .crc_done_i (crc_valid_o),
        .load_o     (load),
        .step_o     (step),
        .busy_o     (busy_o)
    );

    lfsr_prbs_gen u_gen (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .load_i (load),
        .seed_i (seed_i),
        .poly_i (poly_i),
        .step_i (step),
        .word_o (word_o)
    );

    lfsr_crc_engine #(.CRC_W(CRC_W)) u_crc (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .init_i      (load),
        .word_i      (word_o),
        .crc_o       (crc_o),
        .crc_valid_o (crc_valid_o)
    );

endmodule

// File: lfsr_pkg.sv
//********************************************************************
// shared types for the frame pattern source: word, length, step and
// stream types, controller state encoding and default widths.
//********************************************************************

package lfsr_pkg;

    //****************************************************************
    // widths
    //****************************************************************

    localparam int WORD_W    = 16;  // pattern word, seed and poly.
    localparam int LEN_W     = 8;   // frame length counter.
    localparam int CRC_W_DEF = 32;  // default crc width.

    typedef logic [WORD_W-1:0] word_t;  // pattern word, seed or tap mask.
    typedef logic [LEN_W-1:0]  len_t;   // frame length in words, 1..255.

    //****************************************************************
    // bundles
    //****************************************************************

    // one generator command, issued once per word.
    typedef struct packed {
        logic step;  // advance the lfsr and emit a word.
        logic last;  // this word closes the frame.
    } step_t;

    // one generated word on its way to the crc engine.
    typedef struct packed {
        logic  valid;
        logic  last;
        word_t data;
    } stream_t;

    //****************************************************************
    // controller states
    //****************************************************************

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        RUN      = 2'd1,
        WAIT_CRC = 2'd2
    } frame_state_e;

endpackage

// File: lfsr_prbs_gen.sv
//********************************************************************
// loadable fibonacci lfsr, one registered pattern word per step.
//********************************************************************

`timescale 1ns/100ps

module lfsr_prbs_gen (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              load_i,
    input  lfsr_pkg::word_t   seed_i,
    input  lfsr_pkg::word_t   poly_i,
    input  lfsr_pkg::step_t   step_i,
    output lfsr_pkg::stream_t word_o
);

    lfsr_pkg::word_t lfsr_q;    // current lfsr state.
    lfsr_pkg::word_t poly_q;    // tap mask captured at load.
    logic            feedback;

    // parity of the tapped bits enters at bit 0.
    assign feedback = ^(lfsr_q & poly_q);

    // state register, seed and taps are only taken on load.
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            lfsr_q <= seed_i;
            poly_q <= poly_i;
        end else if (step_i.step) begin
            lfsr_q <= {lfsr_q[lfsr_pkg::WORD_W-2:0], feedback};
        end
    end

    // output strobes.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            word_o.valid <= 1'b0;
            word_o.last  <= 1'b0;
        end else begin
            word_o.valid <= step_i.step;
            word_o.last  <= step_i.step & step_i.last;
        end
    end

    // the word sent out is the state before it advances.
    always_ff @(posedge clk_i) begin
        if (step_i.step) begin
            word_o.data <= lfsr_q;
        end
    end

endmodule

// File: sim.f
+incdir+.
lfsr_pkg.sv
lfsr_prbs_gen.sv
lfsr_crc_engine.sv
lfsr_frame_ctrl.sv
lfsr_frame_top.sv
lfsr_frame_tb.sv
